//--- common/clock_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Timekeeping widths and tick constants
////////////////////////////////////////////////////////////////////////////

package clock_pkg;

  // One BCD digit of hours or minutes
  typedef logic [3:0] bcd_digit_t;

  // Tick position inside one minute, 256 ticks per second
  typedef logic [13:0] tick_count_t;

  // Tick count that marks one full minute (60 x 256)
  localparam tick_count_t TICKS_PER_MINUTE = 14'd15360;

  // Low 8 count bits at the last tick of each second
  localparam logic [7:0] SECOND_TICK_MASK_LAST = 8'd255;

  // Digit limits for rollover
  // Tens of hours never pass 2
  localparam bcd_digit_t MAX_MS_HOUR = 4'd2;
  // Units of hours stop at 3 when the tens digit is 2
  localparam bcd_digit_t MAX_LS_HOUR_AT_TWO = 4'd3;
  // Tens of minutes stop at 5
  localparam bcd_digit_t MAX_MS_MINUTE = 4'd5;
  // Any units digit stops at 9
  localparam bcd_digit_t MAX_LS_DIGIT = 4'd9;

endpackage

`default_nettype wire

//--- common/ui_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Keypad, controller and LCD definitions
////////////////////////////////////////////////////////////////////////////

package ui_pkg;

  // Keypad code, 0 to 9 are digit keys
  typedef logic [3:0] key_code_t;

  // Code seen on the keypad lines while nothing is pressed
  localparam key_code_t NO_KEY = 4'd10;

  // One ASCII character sent to the LCD
  typedef logic [7:0] lcd_char_t;

  // Character for digit 0, digits follow in order
  localparam lcd_char_t LCD_ZERO = 8'h30;
  // Shown for any value above 9 (':')
  localparam lcd_char_t LCD_ERROR = 8'h3A;

  // Seconds of inactivity before key entry is dropped
  localparam logic [3:0] ENTRY_TIMEOUT_SECONDS = 4'd9;

  // Controller states
  typedef enum logic [2:0] {
    SHOW_TIME        = 3'b000,
    KEY_ENTRY        = 3'b001,
    KEY_STORED       = 3'b010,
    SHOW_ALARM       = 3'b011,
    SET_ALARM_TIME   = 3'b100,
    SET_CURRENT_TIME = 3'b101,
    KEY_WAITED       = 3'b110
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/tick_generator.sv
`timescale 1ns/1ps
`default_nettype none

module tick_generator (
  input  logic clock,
  input  logic reset,
  input  logic restart,
  input  logic fastwatch,
  output logic one_second,
  output logic one_minute
);

  import clock_pkg::*;

  tick_count_t tick_count;
  logic        minute_pulse;

  // Free running tick count, wraps once per minute
  // Restart realigns the second boundary with a newly set time
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      tick_count   <= '0;
      minute_pulse <= 1'b0;
      one_second   <= 1'b0;
    end
    else if (restart)
    begin
      tick_count   <= '0;
      minute_pulse <= 1'b0;
      one_second   <= 1'b0;
    end
    else
    begin
      if (tick_count == TICKS_PER_MINUTE - 14'd1)
        tick_count <= '0;
      else
        tick_count <= tick_count + 14'd1;
      minute_pulse <= (tick_count == TICKS_PER_MINUTE - 14'd1);
      // Second pulse on the last tick of every 256
      one_second <= (tick_count[7:0] == SECOND_TICK_MASK_LAST);
    end
  end

  // Fastwatch turns every second into a minute
  assign one_minute = fastwatch ? one_second : minute_pulse;

  // Seconds are single clock pulses, never back to back
  a_second_single: assert property (
    @(posedge clock) disable iff (reset) one_second |=> !one_second
  ) else $error("one_second held high for two cycles");

endmodule

`default_nettype wire

//--- hw/time_counter.sv
`timescale 1ns/1ps
`default_nettype none

module time_counter (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 one_minute,
  input  logic                 load,
  input  clock_pkg::bcd_digit_t new_ms_hour,
  input  clock_pkg::bcd_digit_t new_ls_hour,
  input  clock_pkg::bcd_digit_t new_ms_minute,
  input  clock_pkg::bcd_digit_t new_ls_minute,
  output clock_pkg::bcd_digit_t ms_hour,
  output clock_pkg::bcd_digit_t ls_hour,
  output clock_pkg::bcd_digit_t ms_minute,
  output clock_pkg::bcd_digit_t ls_minute
);

  import clock_pkg::*;

  logic minutes_at_59;
  logic valid_load;

  assign minutes_at_59 = (ms_minute == MAX_MS_MINUTE) && (ls_minute == MAX_LS_DIGIT);

  // Load wins over counting
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      ms_hour   <= '0;
      ls_hour   <= '0;
      ms_minute <= '0;
      ls_minute <= '0;
    end
    else if (load)
    begin
      ms_hour   <= new_ms_hour;
      ls_hour   <= new_ls_hour;
      ms_minute <= new_ms_minute;
      ls_minute <= new_ls_minute;
    end
    else if (one_minute)
    begin
      // 23:59 wraps to midnight
      if (ms_hour == MAX_MS_HOUR && ls_hour == MAX_LS_HOUR_AT_TWO && minutes_at_59)
      begin
        ms_hour   <= '0;
        ls_hour   <= '0;
        ms_minute <= '0;
        ls_minute <= '0;
      end
      // x9:59 carries into the tens of hours
      else if (ls_hour == MAX_LS_DIGIT && minutes_at_59)
      begin
        ms_hour   <= ms_hour + 4'd1;
        ls_hour   <= '0;
        ms_minute <= '0;
        ls_minute <= '0;
      end
      // xx:59 carries into the hours
      else if (minutes_at_59)
      begin
        ls_hour   <= ls_hour + 4'd1;
        ms_minute <= '0;
        ls_minute <= '0;
      end
      else if (ls_minute == MAX_LS_DIGIT)
      begin
        ms_minute <= ms_minute + 4'd1;
        ls_minute <= '0;
      end
      else
        ls_minute <= ls_minute + 4'd1;
    end
  end

  // A real 24-hour time on the load inputs
  assign valid_load =
    ((new_ms_hour < MAX_MS_HOUR && new_ls_hour <= MAX_LS_DIGIT) ||
     (new_ms_hour == MAX_MS_HOUR && new_ls_hour <= MAX_LS_HOUR_AT_TWO)) &&
    new_ms_minute <= MAX_MS_MINUTE && new_ls_minute <= MAX_LS_DIGIT;

  // Counting from a valid time never walks past 2x hours
  a_hour_in_range: assert property (
    @(posedge clock) disable iff (reset)
    (load && valid_load) |=> ((ms_hour <= MAX_MS_HOUR) until load)
  ) else $error("tens of hours left 0..2 after a valid load");

endmodule

`default_nettype wire

//--- hw/entry_store.sv
`timescale 1ns/1ps
`default_nettype none

module entry_store (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  shift,
  input  ui_pkg::key_code_t     key,
  input  logic                  load_alarm,
  output clock_pkg::bcd_digit_t key_ms_hour,
  output clock_pkg::bcd_digit_t key_ls_hour,
  output clock_pkg::bcd_digit_t key_ms_minute,
  output clock_pkg::bcd_digit_t key_ls_minute,
  output clock_pkg::bcd_digit_t alarm_ms_hour,
  output clock_pkg::bcd_digit_t alarm_ls_hour,
  output clock_pkg::bcd_digit_t alarm_ms_minute,
  output clock_pkg::bcd_digit_t alarm_ls_minute
);

  // Key buffer keeps the last four keys, newest on the right
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      key_ms_hour   <= '0;
      key_ls_hour   <= '0;
      key_ms_minute <= '0;
      key_ls_minute <= '0;
    end
    else if (shift)
    begin
      key_ms_hour   <= key_ls_hour;
      key_ls_hour   <= key_ms_minute;
      key_ms_minute <= key_ls_minute;
      key_ls_minute <= key;
    end
  end

  // Alarm time, taken from the buffer as a whole
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      alarm_ms_hour   <= '0;
      alarm_ls_hour   <= '0;
      alarm_ms_minute <= '0;
      alarm_ls_minute <= '0;
    end
    else if (load_alarm)
    begin
      alarm_ms_hour   <= key_ms_hour;
      alarm_ls_hour   <= key_ls_hour;
      alarm_ms_minute <= key_ms_minute;
      alarm_ls_minute <= key_ls_minute;
    end
  end

endmodule

`default_nettype wire

//--- control/clock_controller.sv
`timescale 1ns/1ps
`default_nettype none

module clock_controller (
  input  logic              clock,
  input  logic              reset,
  input  logic              one_second,
  input  ui_pkg::key_code_t key,
  input  logic              time_button,
  input  logic              alarm_button,
  output logic              shift,
  output logic              load_current,
  output logic              load_alarm,
  output logic              show_alarm,
  output logic              show_entry
);

  import clock_pkg::*;
  import ui_pkg::*;

  ctrl_state_t state;
  ctrl_state_t next_state;
  // Seconds spent in the current entry state, 0..9
  bcd_digit_t  idle_seconds;
  logic        in_entry;
  logic        timeout;

  ////////////////////////////////////////////////////////////////////////////
  // Entry timeout
  ////////////////////////////////////////////////////////////////////////////

  assign in_entry = (state == KEY_WAITED) || (state == KEY_ENTRY);
  assign timeout  = (idle_seconds == ENTRY_TIMEOUT_SECONDS);

  // Restarts whenever the FSM moves, so each key gets its own 9 s
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      idle_seconds <= '0;
    else if (!in_entry || next_state != state)
      idle_seconds <= '0;
    else if (one_second && !timeout)
      idle_seconds <= idle_seconds + 4'd1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
      state <= SHOW_TIME;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      SHOW_TIME:
        if (alarm_button)
          next_state = SHOW_ALARM;
        else if (key != NO_KEY)
          next_state = KEY_STORED;
      // One cycle here gives exactly one shift per press
      KEY_STORED:
        next_state = KEY_WAITED;
      // Wait for the key to be let go
      KEY_WAITED:
        if (key == NO_KEY)
          next_state = KEY_ENTRY;
        else if (timeout)
          next_state = SHOW_TIME;
      KEY_ENTRY:
        if (alarm_button)
          next_state = SET_ALARM_TIME;
        else if (time_button)
          next_state = SET_CURRENT_TIME;
        else if (timeout)
          next_state = SHOW_TIME;
        else if (key != NO_KEY)
          next_state = KEY_STORED;
      SHOW_ALARM:
        if (!alarm_button)
          next_state = SHOW_TIME;
      SET_ALARM_TIME,
      SET_CURRENT_TIME:
        next_state = SHOW_TIME;
      default:
        next_state = SHOW_TIME;
    endcase
  end

  // Moore outputs
  assign shift        = (state == KEY_STORED);
  assign load_current = (state == SET_CURRENT_TIME);
  assign load_alarm   = (state == SET_ALARM_TIME);
  assign show_alarm   = (state == SHOW_ALARM);
  assign show_entry   = in_entry || (state == KEY_STORED);

  // Time and alarm loads are exclusive and single cycle
  a_loads_exclusive: assert property (
    @(posedge clock) disable iff (reset) !(load_alarm && load_current)
  ) else $error("time and alarm loaded together");

  a_load_alarm_pulse: assert property (
    @(posedge clock) disable iff (reset) load_alarm |=> !load_alarm
  ) else $error("load_alarm longer than one cycle");

  a_load_current_pulse: assert property (
    @(posedge clock) disable iff (reset) load_current |=> !load_current
  ) else $error("load_current longer than one cycle");

endmodule

`default_nettype wire

//--- display/lcd_digit.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_digit (
  input  clock_pkg::bcd_digit_t current_digit,
  input  clock_pkg::bcd_digit_t alarm_digit,
  input  clock_pkg::bcd_digit_t key_digit,
  input  logic                  show_alarm,
  input  logic                  show_entry,
  output ui_pkg::lcd_char_t     lcd_char,
  output logic                  digit_match
);

  import clock_pkg::*;
  import ui_pkg::*;

  bcd_digit_t shown;

  // Key entry overrides the alarm view
  always_comb
  begin
    if (show_entry)
      shown = key_digit;
    else if (show_alarm)
      shown = alarm_digit;
    else
      shown = current_digit;
  end

  // ASCII digits are contiguous from '0'
  always_comb
  begin
    if (shown > MAX_LS_DIGIT)
      lcd_char = LCD_ERROR;
    else
      lcd_char = LCD_ZERO + lcd_char_t'(shown);
  end

  // Per digit part of the alarm compare
  assign digit_match = (current_digit == alarm_digit);

endmodule

`default_nettype wire

//--- display/lcd_driver_4.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_driver_4 (
  input  clock_pkg::bcd_digit_t current_ms_hour,
  input  clock_pkg::bcd_digit_t current_ls_hour,
  input  clock_pkg::bcd_digit_t current_ms_minute,
  input  clock_pkg::bcd_digit_t current_ls_minute,
  input  clock_pkg::bcd_digit_t alarm_ms_hour,
  input  clock_pkg::bcd_digit_t alarm_ls_hour,
  input  clock_pkg::bcd_digit_t alarm_ms_minute,
  input  clock_pkg::bcd_digit_t alarm_ls_minute,
  input  clock_pkg::bcd_digit_t key_ms_hour,
  input  clock_pkg::bcd_digit_t key_ls_hour,
  input  clock_pkg::bcd_digit_t key_ms_minute,
  input  clock_pkg::bcd_digit_t key_ls_minute,
  input  logic                  show_alarm,
  input  logic                  show_entry,
  output ui_pkg::lcd_char_t     ms_hour_char,
  output ui_pkg::lcd_char_t     ls_hour_char,
  output ui_pkg::lcd_char_t     ms_minute_char,
  output ui_pkg::lcd_char_t     ls_minute_char,
  output logic                  alarm_sound
);

  logic [3:0] match;

  // One driver per display position, ms hour first
  lcd_digit i_ms_hour (.current_digit(current_ms_hour), .alarm_digit(alarm_ms_hour),
    .key_digit(key_ms_hour), .show_alarm(show_alarm), .show_entry(show_entry),
    .lcd_char(ms_hour_char), .digit_match(match[3]));

  lcd_digit i_ls_hour (.current_digit(current_ls_hour), .alarm_digit(alarm_ls_hour),
    .key_digit(key_ls_hour), .show_alarm(show_alarm), .show_entry(show_entry),
    .lcd_char(ls_hour_char), .digit_match(match[2]));

  lcd_digit i_ms_minute (.current_digit(current_ms_minute), .alarm_digit(alarm_ms_minute),
    .key_digit(key_ms_minute), .show_alarm(show_alarm), .show_entry(show_entry),
    .lcd_char(ms_minute_char), .digit_match(match[1]));

  lcd_digit i_ls_minute (.current_digit(current_ls_minute), .alarm_digit(alarm_ls_minute),
    .key_digit(key_ls_minute), .show_alarm(show_alarm), .show_entry(show_entry),
    .lcd_char(ls_minute_char), .digit_match(match[0]));

  // Sounds for the whole minute the times agree
  assign alarm_sound = &match;

endmodule

`default_nettype wire

//--- hw/alarm_clock_top.sv
`timescale 1ns/1ps
`default_nettype none

module alarm_clock_top (
  input  logic              clock,
  input  logic              reset,
  input  ui_pkg::key_code_t key,
  input  logic              time_button,
  input  logic              alarm_button,
  input  logic              fastwatch,
  output ui_pkg::lcd_char_t ms_hour,
  output ui_pkg::lcd_char_t ls_hour,
  output ui_pkg::lcd_char_t ms_minute,
  output ui_pkg::lcd_char_t ls_minute,
  output logic              alarm_sound
);

  import clock_pkg::*;

  logic one_second;
  logic one_minute;
  logic shift;
  logic load_current;
  logic load_alarm;
  logic show_alarm;
  logic show_entry;

  // Key buffer, current time and alarm time digits
  bcd_digit_t key_ms_hour, key_ls_hour, key_ms_minute, key_ls_minute;
  bcd_digit_t cur_ms_hour, cur_ls_hour, cur_ms_minute, cur_ls_minute;
  bcd_digit_t alm_ms_hour, alm_ls_hour, alm_ms_minute, alm_ls_minute;

  // Setting the time also restarts the second count
  tick_generator i_tick_generator (.clock(clock), .reset(reset), .restart(load_current),
    .fastwatch(fastwatch), .one_second(one_second), .one_minute(one_minute));

  time_counter i_time_counter (.clock(clock), .reset(reset), .one_minute(one_minute),
    .load(load_current), .new_ms_hour(key_ms_hour), .new_ls_hour(key_ls_hour),
    .new_ms_minute(key_ms_minute), .new_ls_minute(key_ls_minute),
    .ms_hour(cur_ms_hour), .ls_hour(cur_ls_hour),
    .ms_minute(cur_ms_minute), .ls_minute(cur_ls_minute));

  entry_store i_entry_store (.clock(clock), .reset(reset), .shift(shift), .key(key),
    .load_alarm(load_alarm), .key_ms_hour(key_ms_hour), .key_ls_hour(key_ls_hour),
    .key_ms_minute(key_ms_minute), .key_ls_minute(key_ls_minute),
    .alarm_ms_hour(alm_ms_hour), .alarm_ls_hour(alm_ls_hour),
    .alarm_ms_minute(alm_ms_minute), .alarm_ls_minute(alm_ls_minute));

  clock_controller i_clock_controller (.clock(clock), .reset(reset),
    .one_second(one_second), .key(key), .time_button(time_button),
    .alarm_button(alarm_button), .shift(shift), .load_current(load_current),
    .load_alarm(load_alarm), .show_alarm(show_alarm), .show_entry(show_entry));

  lcd_driver_4 i_lcd_driver_4 (
    .current_ms_hour(cur_ms_hour), .current_ls_hour(cur_ls_hour),
    .current_ms_minute(cur_ms_minute), .current_ls_minute(cur_ls_minute),
    .alarm_ms_hour(alm_ms_hour), .alarm_ls_hour(alm_ls_hour),
    .alarm_ms_minute(alm_ms_minute), .alarm_ls_minute(alm_ls_minute),
    .key_ms_hour(key_ms_hour), .key_ls_hour(key_ls_hour),
    .key_ms_minute(key_ms_minute), .key_ls_minute(key_ls_minute),
    .show_alarm(show_alarm), .show_entry(show_entry),
    .ms_hour_char(ms_hour), .ls_hour_char(ls_hour),
    .ms_minute_char(ms_minute), .ls_minute_char(ls_minute),
    .alarm_sound(alarm_sound));

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  // 40 ns period
  initial
  begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Reset held over the first 8 rising edges
  initial
  begin
    reset = 1'b1;
    repeat (8) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- tb/alarm_clock_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alarm_clock_tb;

  import clock_pkg::*;
  import ui_pkg::*;

  logic      clock;
  logic      reset;
  key_code_t key;
  logic      time_button;
  logic      alarm_button;
  logic      fastwatch;
  lcd_char_t ms_hour;
  lcd_char_t ls_hour;
  lcd_char_t ms_minute;
  lcd_char_t ls_minute;
  logic      alarm_sound;

  // Reference digits packed as hh:mm nibbles
  logic [15:0] model_cur;
  logic [15:0] model_alarm;
  logic [15:0] model_key;
  logic [15:0] requested_time;
  logic        time_request;
  logic        alarm_request;

  string test_name;
  int    error_count = 0;
  int    test_count = 0;
  int    failed_count = 0;
  int    errors_at_start = 0;

  tb_clock_gen i_tb_clock_gen (.clock(clock), .reset(reset));

  alarm_clock_top i_alarm_clock_top (.clock(clock), .reset(reset), .key(key),
    .time_button(time_button), .alarm_button(alarm_button), .fastwatch(fastwatch),
    .ms_hour(ms_hour), .ls_hour(ls_hour), .ms_minute(ms_minute),
    .ls_minute(ls_minute), .alarm_sound(alarm_sound));

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // One minute later in 24-hour BCD
  function automatic logic [15:0] next_minute(input logic [15:0] t);
    if (t == 16'h2359)
      return 16'h0000;
    if (t[11:8] == 4'd9 && t[7:0] == 8'h59)
      return {t[15:12] + 4'd1, 12'h000};
    if (t[7:0] == 8'h59)
      return {t[15:12], t[11:8] + 4'd1, 8'h00};
    if (t[3:0] == 4'd9)
      return {t[15:8], t[7:4] + 4'd1, 4'h0};
    return {t[15:4], t[3:0] + 4'd1};
  endfunction

  // ASCII digit or a colon for anything above 9
  function automatic lcd_char_t to_char(input logic [3:0] d);
    return (d > 4'd9) ? 8'h3A : 8'h30 + {4'h0, d};
  endfunction

  function automatic logic [31:0] expected_chars(input logic [15:0] t);
    return {to_char(t[15:12]), to_char(t[11:8]), to_char(t[7:4]), to_char(t[3:0])};
  endfunction

  function automatic logic [31:0] display_word();
    return {ms_hour, ls_hour, ms_minute, ls_minute};
  endfunction

  function automatic logic char_ok(input lcd_char_t c);
    return (c >= 8'h30) && (c <= 8'h3A);
  endfunction

  // Loads win over counting
  // Minutes step on the DUT minute pulse
  always @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      model_cur   <= '0;
      model_alarm <= '0;
    end
    else
    begin
      if (time_request)
        model_cur <= requested_time;
      else if (i_alarm_clock_top.one_minute)
        model_cur <= next_minute(model_cur);
      if (alarm_request)
        model_alarm <= model_key;
    end
  end

  // Alarm output follows the model after every minute step
  alarm_follows_model: assert property (
    @(posedge clock) disable iff (reset)
    i_alarm_clock_top.one_minute |=> (alarm_sound == (model_cur == model_alarm))
  ) else
  begin
    $display("mismatch %s alarm_sound: expected %0b actual %0b", test_name,
      model_cur == model_alarm, alarm_sound);
    error_count++;
  end

  // LCD only ever sees digits or the colon
  chars_in_range: assert property (
    @(posedge clock) disable iff (reset)
    char_ok(ms_hour) && char_ok(ls_hour) && char_ok(ms_minute) && char_ok(ls_minute)
  ) else
  begin
    $display("mismatch %s display range: expected 30..3a actual %h", test_name,
      display_word());
    error_count++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and check helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = error_count;
  endtask

  task automatic finish_test();
    test_count++;
    if (error_count == errors_at_start)
      $display("test %s: pass", test_name);
    else
    begin
      failed_count++;
      $display("test %s: fail, %0d errors", test_name, error_count - errors_at_start);
    end
  endtask

  task automatic check_equal(input string what, input logic [31:0] expected,
    input logic [31:0] actual);
    assert (actual == expected)
    else
    begin
      $display("mismatch %s %s: expected %h actual %h", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  // Hold then release for 3 to 8 cycles each
  task automatic press_key(input key_code_t k);
    int hold_len;
    int release_len;
    hold_len = 3 + ($urandom % 6);
    release_len = 3 + ($urandom % 6);
    @(posedge clock);
    key <= k;
    repeat (hold_len) @(posedge clock);
    key <= NO_KEY;
    repeat (release_len) @(posedge clock);
    model_key = {model_key[11:0], k};
  endtask

  task automatic enter_time(input logic [15:0] t);
    press_key(t[15:12]);
    press_key(t[11:8]);
    press_key(t[7:4]);
    press_key(t[3:0]);
  endtask

  // Button is seen at the next edge and the copy lands one edge later
  task automatic press_time_button();
    @(posedge clock);
    time_button <= 1'b1;
    requested_time <= model_key;
    @(posedge clock);
    time_button <= 1'b0;
    time_request <= 1'b1;
    @(posedge clock);
    time_request <= 1'b0;
  endtask

  task automatic press_alarm_button();
    @(posedge clock);
    alarm_button <= 1'b1;
    @(posedge clock);
    alarm_button <= 1'b0;
    alarm_request <= 1'b1;
    @(posedge clock);
    alarm_request <= 1'b0;
  endtask

  task automatic wait_reset_release(input int limit);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (reset && cycles < limit)
    begin
      @(negedge clock);
      cycles++;
    end
    if (reset)
    begin
      $display("timeout: reset still high after %0d cycles", limit);
      error_count++;
    end
  endtask

  task automatic wait_display(input logic [31:0] expected, input int limit);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (display_word() !== expected && cycles < limit)
    begin
      @(negedge clock);
      cycles++;
    end
    if (display_word() !== expected)
    begin
      $display("timeout in %s: display never showed %h within %0d cycles",
        test_name, expected, limit);
      error_count++;
    end
  endtask

  // Current time may move while waiting, so follow the model
  task automatic wait_current_time(input int limit);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (display_word() !== expected_chars(model_cur) && cycles < limit)
    begin
      @(negedge clock);
      cycles++;
    end
    if (display_word() !== expected_chars(model_cur))
    begin
      $display("timeout in %s: display did not return to the time within %0d cycles",
        test_name, limit);
      error_count++;
    end
  endtask

  task automatic wait_alarm_sound(input logic level, input int limit);
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (alarm_sound !== level && cycles < limit)
    begin
      @(negedge clock);
      cycles++;
    end
    if (alarm_sound !== level)
    begin
      $display("timeout in %s: alarm_sound never went to %0b within %0d cycles",
        test_name, level, limit);
      error_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    key_code_t   lone_key;
    void'($urandom(32'h97d9_0ff6));
    key <= NO_KEY;
    time_button <= 1'b0;
    alarm_button <= 1'b0;
    fastwatch <= 1'b0;
    time_request <= 1'b0;
    alarm_request <= 1'b0;
    requested_time <= '0;
    model_key = '0;
    test_name = "reset";
    wait_reset_release(20);

    // Midnight on both so the alarm sounds at once
    start_test("reset_state");
    check_equal("display", 32'h3030_3030, display_word());
    check_equal("alarm_sound", 32'd1, {31'd0, alarm_sound});
    finish_test();

    start_test("key_entry");
    for (int k = 1; k <= 4; k++)
    begin
      press_key(key_code_t'(k));
      @(negedge clock);
      check_equal("entry display", expected_chars(model_key), display_word());
    end
    check_equal("four keys", 32'h3132_3334, display_word());
    press_key(4'd12);
    @(negedge clock);
    check_equal("non-digit key", 32'h3233_343A, display_word());
    wait_current_time(2816);
    finish_test();

    // Each second steps a minute in fastwatch
    start_test("midnight_rollover");
    @(posedge clock);
    fastwatch <= 1'b1;
    enter_time(16'h2358);
    press_time_button();
    @(negedge clock);
    check_equal("time set", expected_chars(16'h2358), display_word());
    wait_display(expected_chars(next_minute(16'h2358)), 600);
    wait_display(expected_chars(16'h0000), 600);
    check_equal("alarm at midnight", {31'd0, model_cur == model_alarm}, {31'd0, alarm_sound});
    finish_test();

    start_test("alarm");
    @(posedge clock);
    fastwatch <= 1'b0;
    enter_time(16'h0001);
    press_alarm_button();
    @(negedge clock);
    check_equal("alarm_sound after set", 32'd0, {31'd0, alarm_sound});
    @(posedge clock);
    alarm_button <= 1'b1;
    wait_display(expected_chars(16'h0001), 10);
    check_equal("alarm view", expected_chars(model_alarm), display_word());
    @(posedge clock);
    alarm_button <= 1'b0;
    wait_current_time(10);
    @(posedge clock);
    fastwatch <= 1'b1;
    wait_alarm_sound(1'b1, 600);
    check_equal("alarm minute", expected_chars(16'h0001), display_word());
    wait_alarm_sound(1'b0, 600);
    check_equal("minute after alarm", expected_chars(16'h0002), display_word());
    finish_test();

    // A lone key whose entry is dropped by the 9 s timeout
    start_test("entry_timeout");
    @(posedge clock);
    fastwatch <= 1'b0;
    lone_key = key_code_t'($urandom % 10);
    press_key(lone_key);
    @(negedge clock);
    check_equal("entry display", expected_chars(model_key), display_word());
    wait_current_time(2816);
    finish_test();

    start_test("normal_minute");
    enter_time(16'h1959);
    press_time_button();
    @(negedge clock);
    check_equal("time set", expected_chars(16'h1959), display_word());
    wait_display(expected_chars(next_minute(16'h1959)), 15400);
    check_equal("model time", expected_chars(model_cur), display_word());
    finish_test();

    $display("summary: %0d tests, %0d failed, %0d errors", test_count, failed_count,
      error_count);
    if (error_count == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
common/clock_pkg.sv
common/ui_pkg.sv
hw/tick_generator.sv
hw/time_counter.sv
hw/entry_store.sv
control/clock_controller.sv
display/lcd_digit.sv
display/lcd_driver_4.sv
hw/alarm_clock_top.sv
tb/tb_clock_gen.sv
tb/alarm_clock_tb.sv
